// ==== tests/aluCoreStim.txt ====
# columns (hex): instValid, instruction word, expected wbValid, expected wbAddr, expected wbData
# expected values show up two cycles after the line is driven
1 24011234 1 01 00001234
1 2402fffe 1 02 fffffffe
1 34038001 1 03 00008001
1 3c048000 1 04 80000000
1 20057fff 1 05 00007fff
1 00223021 1 06 00001232
1 00c13823 1 07 fffffffe
1 00e34024 1 08 00008000
1 01014825 1 09 00009234
1 01225026 1 0a ffff6dca
1 01405827 1 0b 00009235
1 00846020 1 0c 00000000
1 00856822 1 0d 7fff8001
1 0041702a 1 0e 00000001
1 0041782b 1 0f 00000000
1 2830ffff 1 10 00000000
1 2c31ffff 1 11 00000001
1 00019100 1 12 00012340
1 00049a02 1 13 00800000
1 0004a203 1 14 ff800000
1 24150024 1 15 00000024
1 02a1b004 1 16 00012340
1 02a2b806 1 17 0fffffff
1 02a2c007 1 18 ffffffff
1 000ac903 1 19 fffff6dc
1 00000000 0 00 00000000
1 8c250000 0 00 00000000
1 24005555 0 00 00000000
0 241a0001 0 00 00000000
1 0005d025 1 1a 00007fff
1 0000d821 1 1b 00000000
1 00220018 0 00 00000000
0 00000000 0 00 00000000

// ==== build.f ====
design/mipsPkg.sv
design/stageIfs.sv
design/instDecode.sv
design/aluExecute.sv
design/regWriteback.sv
design/aluCore.sv
tests/aluCore_props.sv
tests/aluCoreTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = aluCoreTb
FILELIST = build.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== tests/aluCoreTb.sv ====
`timescale 1ns/1ps

module aluCoreTb;

    logic        clk;
    logic        rst;
    logic        instValid;
    logic [31:0] instData;
    logic        wbValid;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;

    // one entry per stimulus line.
    logic        validQ[$];
    logic [31:0] wordQ[$];
    logic        expValidQ[$];
    logic [4:0]  expAddrQ[$];
    logic [31:0] expDataQ[$];
    int          lineNoQ[$];

    int cycleCount = 0;
    int cycleLimit = 10;

    aluCore aluCore_i (
        .clk       (clk),
        .rst       (rst),
        .instValid (instValid),
        .instData  (instData),
        .wbValid   (wbValid),
        .wbAddr    (wbAddr),
        .wbData    (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic loadStimulus();
        int          fd;
        int          got;
        int          fileLine;
        string       line;
        logic        v;
        logic [31:0] w;
        logic        ev;
        logic [4:0]  ea;
        logic [31:0] ed;
        fileLine = 0;
        fd = $fopen("tests/aluCoreStim.txt", "r");
        if (fd == 0) begin
            reportFailure("Could not open the stimulus file tests/aluCoreStim.txt");
        end
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            fileLine++;
            // comments start with a hash, blank lines are skipped.
            if (got > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                got = $sscanf(line, "%h %h %h %h %h", v, w, ev, ea, ed);
                if (got != 5) begin
                    reportFailure($sformatf("Malformed stimulus at file line %0d", fileLine));
                end
                validQ.push_back(v);
                wordQ.push_back(w);
                expValidQ.push_back(ev);
                expAddrQ.push_back(ea);
                expDataQ.push_back(ed);
                lineNoQ.push_back(fileLine);
            end
        end
        $fclose(fd);
    endtask

    task automatic checkLine(input int idx);
        string testName;
        testName = $sformatf("stim line %0d", lineNoQ[idx]);
        assert (wbValid === expValidQ[idx]) else begin
            reportFailure($sformatf("Error: %s wbValid expected %0b actual %0b",
                testName, expValidQ[idx], wbValid));
        end
        // address and data only matter on a write.
        if (expValidQ[idx]) begin
            assert (wbAddr === expAddrQ[idx]) else begin
                reportFailure($sformatf("Error: %s wbAddr expected %0d actual %0d",
                    testName, expAddrQ[idx], wbAddr));
            end
            assert (wbData === expDataQ[idx]) else begin
                reportFailure($sformatf("Error: %s wbData expected %08h actual %08h",
                    testName, expDataQ[idx], wbData));
            end
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                reportFailure($sformatf("Timeout after %0d cycles", cycleCount));
            end
        end
    end

    initial begin
        int lineCount;
        rst       = 1'b1;
        instValid = 1'b0;
        instData  = '0;
        loadStimulus();
        lineCount  = validQ.size();
        cycleLimit = lineCount + 10;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // results trail their line by two edges.
        for (int n = 0; n < lineCount + 2; n++) begin
            @(posedge clk);
            if (n < lineCount) begin
                instValid <= validQ[n];
                instData  <= wordQ[n];
            end else begin
                instValid <= 1'b0;
                instData  <= '0;
            end
            @(negedge clk);
            if (n >= 2) begin
                checkLine(n - 2);
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== tests/aluCore_props.sv ====
`timescale 1ns/1ps

module aluCore_props import mipsPkg::*; (
    input logic                    clk,
    input logic                    rst,
    input logic                    wbValid,
    input logic [regAddrWidth-1:0] wbAddr,
    input logic [dataWidth-1:0]    wbData
);

    // reset clears the write strobe.
    validLowAfterReset: assert property (@(posedge clk) rst |=> !wbValid)
        else $error("wbValid high in the cycle after reset");

    // r0 is never reported as written.
    addrNonzeroOnWrite: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> wbAddr != '0)
        else $error("write reported to register 0");

    dataKnownOnWrite: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> !$isunknown(wbData))
        else $error("wbData has unknown bits during a write");

endmodule

bind aluCore aluCore_props propsCheck (
    .clk     (clk),
    .rst     (rst),
    .wbValid (wbValid),
    .wbAddr  (wbAddr),
    .wbData  (wbData)
);

// ==== design/aluCore.sv ====
`timescale 1ns/1ps

module aluCore import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instValid,
    input  logic [dataWidth-1:0]    instData,
    output logic                    wbValid,
    output logic [regAddrWidth-1:0] wbAddr,
    output logic [dataWidth-1:0]    wbData
);
    logic                    resValid;
    logic [regAddrWidth-1:0] resAddr;
    logic [dataWidth-1:0]    resData;

    uopIf  uopBus ();
    readIf readBus ();

    instDecode decodeStage (
        .clk       (clk),
        .rst       (rst),
        .instValid (instValid),
        .inst      (instData),
        .uop       (uopBus.decode)
    );

    aluExecute executeStage (
        .uop      (uopBus.execute),
        .rd       (readBus.execute),
        .resValid (resValid),
        .resAddr  (resAddr),
        .resData  (resData)
    );

    regWriteback writebackStage (
        .clk      (clk),
        .rst      (rst),
        .rd       (readBus.regs),
        .resValid (resValid),
        .resAddr  (resAddr),
        .resData  (resData),
        .wbValid  (wbValid),
        .wbAddr   (wbAddr),
        .wbData   (wbData)
    );

endmodule

// ==== design/regWriteback.sv ====
`timescale 1ns/1ps

module regWriteback import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    readIf.regs                     rd,
    input  logic                    resValid,
    input  logic [regAddrWidth-1:0] resAddr,
    input  logic [dataWidth-1:0]    resData,
    output logic                    wbValid,
    output logic [regAddrWidth-1:0] wbAddr,
    output logic [dataWidth-1:0]    wbData
);
    logic [dataWidth-1:0] regFile [regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regFile[i] <= '0;
            end
        end else if (resValid) begin
            regFile[resAddr] <= resData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= resValid;
        end
    end

    always_ff @(posedge clk) begin
        wbAddr <= resAddr;
        wbData <= resData;
    end

    // r0 reads as zero.
    assign rd.rData0 = (rd.rAddr0 == '0) ? '0 : regFile[rd.rAddr0];
    assign rd.rData1 = (rd.rAddr1 == '0) ? '0 : regFile[rd.rAddr1];

endmodule

// ==== design/aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute import mipsPkg::*; (
    uopIf.execute                   uop,
    readIf.execute                  rd,
    output logic                    resValid,
    output logic [regAddrWidth-1:0] resAddr,
    output logic [dataWidth-1:0]    resData
);
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [4:0]           shamt;

    assign rd.rAddr0 = uop.src0Addr;
    assign rd.rAddr1 = uop.src1Addr;

    assign opA   = rd.rData0;
    assign opB   = uop.useImm ? uop.imm : rd.rData1;
    assign shamt = uop.shiftByReg ? rd.rData1[4:0] : uop.imm[4:0];

    always_comb begin
        case (uop.op)
            aluAdd:  resData = opA + opB;
            aluSub:  resData = opA - opB;
            aluSlt: begin
                resData = {31'd0, $signed(opA) < $signed(opB)};
            end
            aluSltu: begin
                resData = {31'd0, opA < opB};
            end
            aluAnd:  resData = opA & opB;
            aluOr:   resData = opA | opB;
            aluXor:  resData = opA ^ opB;
            aluNor:  resData = ~(opA | opB);
            aluSll:  resData = opA << shamt;
            aluSrl:  resData = opA >> shamt;
            // arithmetic shift keeps the sign.
            aluSra:  resData = $unsigned($signed(opA) >>> shamt);
            default: resData = '0;
        endcase
    end

    assign resValid = uop.uopValid;
    assign resAddr  = uop.dstAddr;

endmodule

// ==== design/instDecode.sv ====
`timescale 1ns/1ps

module instDecode import mipsPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    instValid,
    input  instWord inst,
    uopIf.decode    uop
);
    logic                    known;
    aluOp                    op;
    logic [regAddrWidth-1:0] src0Addr;
    logic [regAddrWidth-1:0] src1Addr;
    logic [regAddrWidth-1:0] dstAddr;
    logic                    useImm;
    logic                    shiftByReg;
    logic [dataWidth-1:0]    imm;
    logic [dataWidth-1:0]    immSext;
    logic [dataWidth-1:0]    immZext;
    logic [dataWidth-1:0]    immShamt;
    logic [dataWidth-1:0]    immLui;

    assign immSext  = {{16{inst.iFields.imm16[15]}}, inst.iFields.imm16};
    assign immZext  = {16'h0000, inst.iFields.imm16};
    assign immShamt = {27'd0, inst.rFields.shamt};
    assign immLui   = {inst.iFields.imm16, 16'h0000};

    always_comb begin
        known      = 1'b1;
        op         = aluAdd;
        src0Addr   = inst.rFields.rs;
        src1Addr   = inst.rFields.rt;
        dstAddr    = inst.rFields.rd;
        useImm     = 1'b0;
        shiftByReg = 1'b0;
        imm        = immSext;
        if (inst.rFields.opcode == opSpecial) begin
            case (inst.rFields.funct)
                fnSll:          op = aluSll;
                fnSrl:          op = aluSrl;
                fnSra:          op = aluSra;
                fnSllv: begin
                    op         = aluSll;
                    shiftByReg = 1'b1;
                end
                fnSrlv: begin
                    op         = aluSrl;
                    shiftByReg = 1'b1;
                end
                fnSrav: begin
                    op         = aluSra;
                    shiftByReg = 1'b1;
                end
                fnAdd, fnAddu:  op = aluAdd;
                fnSub, fnSubu:  op = aluSub;
                fnAnd:          op = aluAnd;
                fnOr:           op = aluOr;
                fnXor:          op = aluXor;
                fnNor:          op = aluNor;
                fnSlt:          op = aluSlt;
                fnSltu:         op = aluSltu;
                default:        known = 1'b0;
            endcase
            // shifted value comes from rt, a variable amount from rs.
            if (op inside {aluSll, aluSrl, aluSra}) begin
                src0Addr = inst.rFields.rt;
                src1Addr = inst.rFields.rs;
                useImm   = !shiftByReg;
                imm      = immShamt;
            end
        end else begin
            dstAddr = inst.iFields.rt;
            useImm  = 1'b1;
            case (inst.iFields.opcode)
                opAddi, opAddiu: op = aluAdd;
                opSlti:          op = aluSlt;
                opSltiu:         op = aluSltu;
                opAndi: begin
                    op  = aluAnd;
                    imm = immZext;
                end
                opOri: begin
                    op  = aluOr;
                    imm = immZext;
                end
                opXori: begin
                    op  = aluXor;
                    imm = immZext;
                end
                // lui is an or with r0.
                opLui: begin
                    op       = aluOr;
                    src0Addr = '0;
                    imm      = immLui;
                end
                default:         known = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uop.uopValid <= 1'b0;
        end else begin
            uop.uopValid <= instValid && known && (dstAddr != '0);
        end
    end

    always_ff @(posedge clk) begin
        uop.op         <= op;
        uop.src0Addr   <= src0Addr;
        uop.src1Addr   <= src1Addr;
        uop.dstAddr    <= dstAddr;
        uop.useImm     <= useImm;
        uop.imm        <= imm;
        uop.shiftByReg <= shiftByReg;
    end

endmodule

// ==== design/stageIfs.sv ====
`timescale 1ns/1ps

// decoded micro-operation, registered in decode.
interface uopIf import mipsPkg::*; ();
    logic                    uopValid;
    aluOp                    op;
    logic [regAddrWidth-1:0] src0Addr;
    logic [regAddrWidth-1:0] src1Addr;
    logic [regAddrWidth-1:0] dstAddr;
    logic                    useImm;
    logic [dataWidth-1:0]    imm;
    logic                    shiftByReg;

    modport decode (
        output uopValid, op, src0Addr, src1Addr, dstAddr,
        output useImm, imm, shiftByReg
    );

    modport execute (
        input uopValid, op, src0Addr, src1Addr, dstAddr,
        input useImm, imm, shiftByReg
    );
endinterface

// two combinational register file read ports.
interface readIf import mipsPkg::*; ();
    logic [regAddrWidth-1:0] rAddr0;
    logic [regAddrWidth-1:0] rAddr1;
    logic [dataWidth-1:0]    rData0;
    logic [dataWidth-1:0]    rData1;

    modport execute (
        output rAddr0, rAddr1,
        input  rData0, rData1
    );

    modport regs (
        input  rAddr0, rAddr1,
        output rData0, rData1
    );
endinterface

// ==== design/mipsPkg.sv ====
package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount     = 32;

    // major opcodes.
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opAddi    = 6'h08;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opSltiu   = 6'h0b;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;

    // funct codes under opSpecial.
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnSllv = 6'h04;
    localparam logic [5:0] fnSrlv = 6'h06;
    localparam logic [5:0] fnSrav = 6'h07;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSlt,
        aluSltu,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSll,
        aluSrl,
        aluSra
    } aluOp;

    // same word seen as R-type or I-type.
    typedef union packed {
        struct packed {
            logic [5:0]              opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [4:0]              shamt;
            logic [5:0]              funct;
        } rFields;
        struct packed {
            logic [5:0]              opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [15:0]             imm16;
        } iFields;
    } instWord;

endpackage
